// ==== Makefile ====
# Verilator build and run of the read cache testbench

VERILATOR ?= verilator
TOP       ?= read_cache_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the fail result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/read_cache_sva.sv ====
`timescale 1ns/1ps

module read_cache_sva (
   input logic        clk,
   input logic        ctrl_reset,
   input logic        cpu_ack,
   input logic        stat_ack,
   input logic        ar_valid,
   input logic        ar_ready,
   input logic [31:0] ar_addr
);

   ////////////////////////////////////////
   // AXI address channel
   ////////////////////////////////////////
   ar_valid_held: assert property (@(posedge clk) disable iff (ctrl_reset)
      ar_valid && !ar_ready |=> ar_valid)
      else $error("ar_valid dropped before ar_ready");

   ar_addr_stable: assert property (@(posedge clk) disable iff (ctrl_reset)
      ar_valid && !ar_ready |=> $stable(ar_addr))
      else $error("ar_addr changed while waiting for ar_ready");

   // acks are single cycle pulses
   cpu_ack_pulse: assert property (@(posedge clk) disable iff (ctrl_reset)
      cpu_ack |=> !cpu_ack)
      else $error("cpu_ack held for more than one cycle");

   stat_ack_pulse: assert property (@(posedge clk) disable iff (ctrl_reset)
      stat_ack |=> !stat_ack)
      else $error("stat_ack held for more than one cycle");

   reset_quiet: assert property (@(posedge clk)
      ctrl_reset |-> !cpu_ack && !ar_valid)
      else $error("cpu_ack or ar_valid high during reset");

endmodule

bind read_cache read_cache_sva read_cache_sva_i (
   .clk        (clk),
   .ctrl_reset (ctrl_reset),
   .cpu_ack    (cpu_ack),
   .stat_ack   (stat_ack),
   .ar_valid   (ar_valid),
   .ar_ready   (ar_ready),
   .ar_addr    (ar_addr)
);

// ==== dv/read_cache_tb.sv ====
`timescale 1ns/1ps

module read_cache_tb;

   localparam logic [31:0] LFSR_SEED   = 32'hc0a5_b2db;
   localparam int          LINES       = 1 << cache_pkg::INDEX_W;
   localparam int          RAND_READS  = 200;
   localparam int          ALL_READS   = RAND_READS + 40;   // directed reads on top
   // worst miss: ar_ready delay, one gap per beat, fsm overhead
   localparam int          MISS_CYCLES = 4 + 2 * cache_pkg::LINE_WORDS + 12;
   localparam int          CYCLE_LIMIT = ALL_READS * MISS_CYCLES + 1000;
   localparam int          HIT_WAIT    = 4;   // drive edge to the edge that sees cpu_ack

   logic                   clk;
   logic                   ctrl_reset;
   logic                   cpu_req;
   cache_pkg::cache_addr_t cpu_addr;
   logic [31:0]            cpu_rdata;
   logic                   cpu_ack;
   logic                   stat_req;
   logic [3:0]             stat_addr;
   logic [31:0]            stat_data;
   logic                   stat_ack;
   logic [31:0]            ar_addr;
   logic [7:0]             ar_len;
   logic [2:0]             ar_size;
   logic [1:0]             ar_burst;
   logic                   ar_valid;
   logic                   ar_ready;
   logic                   r_valid;
   logic                   r_ready;
   logic [31:0]            r_data;
   logic                   r_last;

   logic [cache_pkg::TAG_W-1:0] ref_tag [LINES];
   logic                        ref_valid [LINES];
   logic [31:0] exp_rdata [$];
   logic [31:0] exp_stat [$];
   logic [31:0] stim_lfsr;
   logic [31:0] axi_lfsr;
   string       test_name = "reset";
   int          errors = 0;
   int          data_checks = 0;
   int          stat_checks = 0;
   int          burst_count = 0;
   int          exp_hits = 0;
   int          exp_misses = 0;
   int          cycle_cnt = 0;

   read_cache #(
      .COUNT_W (32)
   ) read_cache_i (
      .clk        (clk),
      .ctrl_reset (ctrl_reset),
      .cpu_req    (cpu_req),
      .cpu_addr   (cpu_addr),
      .cpu_rdata  (cpu_rdata),
      .cpu_ack    (cpu_ack),
      .stat_req   (stat_req),
      .stat_addr  (stat_addr),
      .stat_data  (stat_data),
      .stat_ack   (stat_ack),
      .ar_addr    (ar_addr),
      .ar_len     (ar_len),
      .ar_size    (ar_size),
      .ar_burst   (ar_burst),
      .ar_valid   (ar_valid),
      .ar_ready   (ar_ready),
      .r_valid    (r_valid),
      .r_ready    (r_ready),
      .r_data     (r_data),
      .r_last     (r_last)
   );

   always #5 clk = ~clk;

   ////////////////////////////////////////
   // reference functions
   ////////////////////////////////////////
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
   endfunction

   // one lfsr step per bit taken
   task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++)
      begin
         state = lfsr_next(state);
         bits  = {bits[30:0], state[0]};
      end
   endtask

   // memory contents, a mix of the whole word address
   function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
      logic [31:0] word_addr;
      word_addr = {2'b00, byte_addr[31:2]};
      return lfsr_next(word_addr ^ LFSR_SEED) ^ {word_addr[15:0], word_addr[31:16]};
   endfunction

   function automatic logic predict_hit(input cache_pkg::cache_addr_t a);
      return ref_valid[a.fields.index] && (ref_tag[a.fields.index] == a.fields.tag);
   endfunction

   task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
      $display("error %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
      errors++;
   endtask

   ////////////////////////////////////////
   // AXI read slave
   ////////////////////////////////////////
   initial
   begin : axi_slave
      logic [31:0] bits;
      logic [31:0] line_base;
      forever
      begin
         @(posedge clk);
         if (!ctrl_reset && ar_valid)
         begin
            take_bits(axi_lfsr, 2, bits);
            repeat (bits) @(posedge clk);   // address stall 0..3
            ar_ready <= 1'b1;
            @(posedge clk);
            ar_ready  <= 1'b0;
            line_base = ar_addr;
            burst_count++;
            if (ar_addr !== {2'b00, cpu_addr.flat[29:6], 6'b0})
               report_mismatch("ar_addr", {2'b00, cpu_addr.flat[29:6], 6'b0}, ar_addr);
            if (ar_len !== 8'd15)
               report_mismatch("ar_len", 32'd15, {24'd0, ar_len});
            if (ar_size !== 3'b010)   // 4 bytes per beat
               report_mismatch("ar_size", 32'd2, {29'd0, ar_size});
            if (ar_burst !== 2'b01)   // incrementing
               report_mismatch("ar_burst", 32'd1, {30'd0, ar_burst});
            for (int beat = 0; beat < cache_pkg::LINE_WORDS; beat++)
            begin
               take_bits(axi_lfsr, 1, bits);
               if (bits[0])
               begin
                  r_valid <= 1'b0;   // gap
                  @(posedge clk);
               end
               r_valid <= 1'b1;
               r_data  <= mem_word(line_base + 4 * beat);
               r_last  <= (beat == cache_pkg::LINE_WORDS - 1);
               @(posedge clk);
               if (!r_ready)
               begin
                  $display("r_ready was low while a read beat was offered");
                  errors++;
               end
            end
            r_valid <= 1'b0;
            r_last  <= 1'b0;
         end
      end
   end

   // compares every ack with the queued expectation
   always @(posedge clk)
   begin : compare
      logic [31:0] expected;
      if (!ctrl_reset && cpu_ack)
      begin
         if (exp_rdata.size() == 0)
         begin
            $display("cpu_ack came with no read outstanding");
            errors++;
         end
         else
         begin
            expected = exp_rdata.pop_front();
            data_checks++;
            if (cpu_rdata !== expected)
               report_mismatch("cpu_rdata", expected, cpu_rdata);
         end
      end
      if (!ctrl_reset && stat_ack)
      begin
         if (exp_stat.size() == 0)
         begin
            $display("stat_ack came with no statistics read outstanding");
            errors++;
         end
         else
         begin
            expected = exp_stat.pop_front();
            stat_checks++;
            if (stat_data !== expected)
               report_mismatch("stat_data", expected, stat_data);
         end
      end
   end

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == CYCLE_LIMIT)
      begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Result: FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////
   task automatic cpu_read(input cache_pkg::cache_addr_t a);
      logic expect_hit;
      int   bursts_before;
      int   waited;
      expect_hit    = predict_hit(a);
      bursts_before = burst_count;
      @(posedge clk);
      cpu_req  <= 1'b1;
      cpu_addr <= a;
      exp_rdata.push_back(mem_word({2'b00, a.flat}));
      @(posedge clk);
      waited = 1;
      while (!cpu_ack)
      begin
         @(posedge clk);
         waited++;
      end
      cpu_req <= 1'b0;   // dropped in the cycle after the ack
      if (expect_hit && waited != HIT_WAIT)
         report_mismatch("hit latency", HIT_WAIT, waited);
      if (burst_count != bursts_before + (expect_hit ? 0 : 1))
         report_mismatch("burst count", bursts_before + (expect_hit ? 0 : 1), burst_count);
      if (expect_hit)
         exp_hits++;
      else
      begin
         exp_misses++;
         ref_valid[a.fields.index] = 1'b1;
         ref_tag[a.fields.index]   = a.fields.tag;
      end
   endtask

   task automatic stat_read(input logic [3:0] code, input logic [31:0] expected);
      @(posedge clk);
      stat_req  <= 1'b1;
      stat_addr <= code;
      exp_stat.push_back(expected);
      @(posedge clk);
      stat_req <= 1'b0;
      while (!stat_ack)
         @(posedge clk);
   endtask

   task automatic check_counters();
      stat_read(cache_pkg::STAT_HITS, exp_hits);
      stat_read(cache_pkg::STAT_MISSES, exp_misses);
      stat_read(cache_pkg::STAT_TOTAL, exp_hits + exp_misses);
   endtask

   initial
   begin : stimulus
      cache_pkg::cache_addr_t addr_a;
      cache_pkg::cache_addr_t addr_b;
      cache_pkg::cache_addr_t ra;
      logic [31:0]            bits;
      clk        = 1'b0;
      ctrl_reset = 1'b1;
      cpu_req    = 1'b0;
      cpu_addr   = '0;
      stat_req   = 1'b0;
      stat_addr  = 4'd0;
      ar_ready   = 1'b0;
      r_valid    = 1'b0;
      r_data     = 32'd0;
      r_last     = 1'b0;
      stim_lfsr  = LFSR_SEED;
      axi_lfsr   = lfsr_next(LFSR_SEED);
      foreach (ref_valid[i])
         ref_valid[i] = 1'b0;
      addr_a = {18'h01234, 6'd5, 4'd3, 2'b00};
      addr_b = {18'h00777, 6'd5, 4'd9, 2'b00};   // same index, other tag
      repeat (5) @(posedge clk);
      ctrl_reset <= 1'b0;

      test_name = "cold_miss";
      cpu_read(addr_a);
      test_name = "line_hit";
      for (int w = 0; w < cache_pkg::LINE_WORDS; w++)
      begin
         ra            = addr_a;
         ra.fields.word = w[3:0];
         cpu_read(ra);
      end
      test_name = "evict";
      cpu_read(addr_b);
      cpu_read(addr_a);
      cpu_read(addr_b);
      test_name = "stats";
      check_counters();
      stat_read(4'd3, 32'd0);    // unused codes
      stat_read(4'd7, 32'd0);
      test_name = "invalidate";
      stat_read(cache_pkg::STAT_INVALIDATE, 32'd0);
      foreach (ref_valid[i])
         ref_valid[i] = 1'b0;
      check_counters();
      cpu_read(addr_b);
      cpu_read(addr_a);

      // small tag and index range so hits recur
      test_name = "random_stall";
      for (int n = 0; n < RAND_READS; n++)
      begin
         take_bits(stim_lfsr, 9, bits);
         ra.fields.tag      = {16'h0a5c, bits[8:7]};
         ra.fields.index    = {3'b000, bits[6:4]};
         ra.fields.word     = bits[3:0];
         ra.fields.byte_off = 2'b00;
         cpu_read(ra);
      end
      check_counters();

      repeat (4) @(posedge clk);
      if (exp_rdata.size() != 0 || exp_stat.size() != 0)
      begin
         $display("some expected acks never arrived");
         errors++;
      end
      $display("data checks %0d, stat checks %0d, bursts %0d, errors %0d",
               data_checks, stat_checks, burst_count, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// ==== filelist.f ====
src/cache_pkg.sv
src/lookup_fsm.sv
src/refill_burst.sv
src/line_store.sv
src/perf_counters.sv
src/read_cache.sv
dv/read_cache_sva.sv
dv/read_cache_tb.sv

// ==== src/cache_pkg.sv ====
package cache_pkg;

   ////////////////////////////////////////
   // cache geometry
   ////////////////////////////////////////
   localparam int ADDR_W     = 30;                // byte address, top two bits dropped
   localparam int WORD_W     = 32;
   localparam int INDEX_W    = 6;                 // 64 lines
   localparam int WORD_SEL_W = 4;                 // 16 words per line
   localparam int TAG_W      = ADDR_W - (INDEX_W + WORD_SEL_W + 2);
   localparam int LINE_WORDS = 1 << WORD_SEL_W;   // also the burst length

   // fixed AXI burst fields
   localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;   // 4 bytes per beat
   localparam logic [1:0] AXI_BURST_INCR = 2'b01;

   // one request address, flat or split into its fields
   typedef union packed {
      logic [ADDR_W-1:0] flat;
      struct packed {
         logic [TAG_W-1:0]      tag;
         logic [INDEX_W-1:0]    index;
         logic [WORD_SEL_W-1:0] word;
         logic [1:0]            byte_off;   // always zero for word access
      } fields;
   } cache_addr_t;

   // statistics port codes, anything else reads zero
   localparam logic [3:0] STAT_HITS       = 4'd0;
   localparam logic [3:0] STAT_MISSES     = 4'd1;
   localparam logic [3:0] STAT_TOTAL      = 4'd2;
   localparam logic [3:0] STAT_INVALIDATE = 4'd15;

endpackage

// ==== src/line_store.sv ====
`timescale 1ns/1ps

module line_store (
   input  logic                               clk,
   input  logic                               ctrl_reset,
   input  cache_pkg::cache_addr_t             cpu_addr,
   input  logic                               fill_we,
   input  logic [cache_pkg::WORD_SEL_W-1:0]   fill_word,
   input  logic [cache_pkg::WORD_W-1:0]       r_data,
   input  logic                               fill_done,
   input  logic                               invalidate,
   output logic                               hit,
   output logic [cache_pkg::WORD_W-1:0]       cpu_rdata
);

   localparam int LINES = 1 << cache_pkg::INDEX_W;
   localparam int DEPTH = LINES * cache_pkg::LINE_WORDS;

   logic [cache_pkg::TAG_W-1:0]  tag_mem [LINES];
   logic [cache_pkg::WORD_W-1:0] data_mem [DEPTH];
   logic [LINES-1:0]             valid;

   logic [cache_pkg::TAG_W-1:0]  tag_q;
   logic                         valid_q;

   logic [cache_pkg::INDEX_W-1:0] index;
   logic [cache_pkg::INDEX_W+cache_pkg::WORD_SEL_W-1:0] rd_ptr;
   logic [cache_pkg::INDEX_W+cache_pkg::WORD_SEL_W-1:0] wr_ptr;

   assign index  = cpu_addr.fields.index;
   assign rd_ptr = {index, cpu_addr.fields.word};
   assign wr_ptr = {index, fill_word};   // cpu_addr held through the refill

   ////////////////////////////////////////
   // valid bits
   ////////////////////////////////////////
   always_ff @(posedge clk or posedge ctrl_reset)
   begin
      if (ctrl_reset)
      begin
         valid   <= '0;
         valid_q <= 1'b0;
      end
      else
      begin
         if (invalidate)
            valid <= '0;        // whole cache at once
         else if (fill_done)
            valid[index] <= 1'b1;
         valid_q <= valid[index];
      end
   end

   // tag array, read before write
   always_ff @(posedge clk)
   begin
      if (fill_done)
         tag_mem[index] <= cpu_addr.fields.tag;
      tag_q <= tag_mem[index];
   end

   // data array, one word per beat on refill
   always_ff @(posedge clk)
   begin
      if (fill_we)
         data_mem[wr_ptr] <= r_data;
      cpu_rdata <= data_mem[rd_ptr];
   end

   assign hit = valid_q && (tag_q == cpu_addr.fields.tag);

endmodule

// ==== src/lookup_fsm.sv ====
`timescale 1ns/1ps

module lookup_fsm (
   input  logic clk,
   input  logic ctrl_reset,
   input  logic cpu_req,
   input  logic hit,
   input  logic fill_done,
   output logic refill_start,
   output logic cpu_ack,
   output logic hit_event,
   output logic miss_event
);

   localparam logic [2:0] S_IDLE    = 3'd0;
   localparam logic [2:0] S_LOOKUP  = 3'd1;
   localparam logic [2:0] S_REFILL  = 3'd2;
   localparam logic [2:0] S_REREAD  = 3'd3;
   localparam logic [2:0] S_RESPOND = 3'd4;
   localparam logic [2:0] S_SETTLE  = 3'd5;

   logic [2:0] state;

   ////////////////////////////////////////
   // request sequencing
   ////////////////////////////////////////
   always_ff @(posedge clk or posedge ctrl_reset)
   begin
      if (ctrl_reset)
      begin
         state        <= S_IDLE;
         refill_start <= 1'b0;
         cpu_ack      <= 1'b0;
         hit_event    <= 1'b0;
         miss_event   <= 1'b0;
      end
      else
      begin
         // all outputs are single cycle pulses
         refill_start <= 1'b0;
         cpu_ack      <= 1'b0;
         hit_event    <= 1'b0;
         miss_event   <= 1'b0;

         case (state)
            S_IDLE:
               if (cpu_req)
                  state <= S_LOOKUP;   // array read starts on this edge

            S_LOOKUP:
            begin
               // tag and valid were read on the previous edge
               if (hit)
               begin
                  state     <= S_RESPOND;
                  hit_event <= 1'b1;
               end
               else
               begin
                  state        <= S_REFILL;
                  refill_start <= 1'b1;
                  miss_event   <= 1'b1;
               end
            end

            S_REFILL:
               if (fill_done)
                  state <= S_REREAD;   // tag written on this edge

            S_REREAD:
               state <= S_RESPOND;    // word read again from the filled line

            S_RESPOND:
            begin
               cpu_ack <= 1'b1;
               state   <= S_SETTLE;
            end

            // requester drops cpu_req while we sit here
            S_SETTLE:
               state <= S_IDLE;

            default:
               state <= S_IDLE;
         endcase
      end
   end

endmodule

// ==== src/perf_counters.sv ====
`timescale 1ns/1ps

module perf_counters #(
   parameter int COUNT_W = 32   // up to WORD_W
) (
   input  logic                          clk,
   input  logic                          ctrl_reset,
   input  logic                          hit_event,
   input  logic                          miss_event,
   input  logic                          stat_req,
   input  logic [3:0]                    stat_addr,
   output logic [cache_pkg::WORD_W-1:0]  stat_data,
   output logic                          stat_ack,
   output logic                          invalidate
);

   logic [COUNT_W-1:0]           hit_cnt;
   logic [COUNT_W-1:0]           miss_cnt;
   logic [COUNT_W-1:0]           total_cnt;
   logic [cache_pkg::WORD_W-1:0] rd_word;

   assign total_cnt = hit_cnt + miss_cnt;   // wraps like the counters

   ////////////////////////////////////////
   // event counting
   ////////////////////////////////////////
   always_ff @(posedge clk or posedge ctrl_reset)
   begin
      if (ctrl_reset)
      begin
         hit_cnt    <= '0;
         miss_cnt   <= '0;
         stat_ack   <= 1'b0;
         invalidate <= 1'b0;
      end
      else
      begin
         if (hit_event)
            hit_cnt <= hit_cnt + 1'b1;
         if (miss_event)
            miss_cnt <= miss_cnt + 1'b1;
         stat_ack   <= stat_req;
         invalidate <= stat_req && (stat_addr == cache_pkg::STAT_INVALIDATE);
      end
   end

   // zero extended readback word
   always_comb
   begin
      rd_word = '0;
      case (stat_addr)
         cache_pkg::STAT_HITS:   rd_word[COUNT_W-1:0] = hit_cnt;
         cache_pkg::STAT_MISSES: rd_word[COUNT_W-1:0] = miss_cnt;
         cache_pkg::STAT_TOTAL:  rd_word[COUNT_W-1:0] = total_cnt;
         default:                rd_word = '0;   // invalidate reads zero too
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (stat_req)
         stat_data <= rd_word;
   end

endmodule

// ==== src/read_cache.sv ====
`timescale 1ns/1ps

module read_cache #(
   parameter int COUNT_W = 32
) (
   input  logic                          clk,
   input  logic                          ctrl_reset,
   // cpu side
   input  logic                          cpu_req,
   input  cache_pkg::cache_addr_t        cpu_addr,
   output logic [cache_pkg::WORD_W-1:0]  cpu_rdata,
   output logic                          cpu_ack,
   // statistics side
   input  logic                          stat_req,
   input  logic [3:0]                    stat_addr,
   output logic [cache_pkg::WORD_W-1:0]  stat_data,
   output logic                          stat_ack,
   // AXI read channels
   output logic [31:0]                   ar_addr,
   output logic [7:0]                    ar_len,
   output logic [2:0]                    ar_size,
   output logic [1:0]                    ar_burst,
   output logic                          ar_valid,
   input  logic                          ar_ready,
   input  logic                          r_valid,
   output logic                          r_ready,
   input  logic [cache_pkg::WORD_W-1:0]  r_data,
   input  logic                          r_last
);

   logic                             refill_start;
   logic                             fill_done;
   logic                             fill_we;
   logic [cache_pkg::WORD_SEL_W-1:0] fill_word;
   logic                             hit;
   logic                             hit_event;
   logic                             miss_event;
   logic                             invalidate;

   // whole line per burst, never changes
   assign ar_len   = 8'(cache_pkg::LINE_WORDS - 1);
   assign ar_size  = cache_pkg::AXI_SIZE_WORD;
   assign ar_burst = cache_pkg::AXI_BURST_INCR;

   ////////////////////////////////////////
   // submodules
   ////////////////////////////////////////
   lookup_fsm lookup_fsm_i (
      .clk          (clk),
      .ctrl_reset   (ctrl_reset),
      .cpu_req      (cpu_req),
      .hit          (hit),
      .fill_done    (fill_done),
      .refill_start (refill_start),
      .cpu_ack      (cpu_ack),
      .hit_event    (hit_event),
      .miss_event   (miss_event)
   );

   refill_burst refill_burst_i (
      .clk          (clk),
      .ctrl_reset   (ctrl_reset),
      .refill_start (refill_start),
      .cpu_addr     (cpu_addr),
      .ar_addr      (ar_addr),
      .ar_valid     (ar_valid),
      .ar_ready     (ar_ready),
      .r_valid      (r_valid),
      .r_ready      (r_ready),
      .r_last       (r_last),
      .fill_we      (fill_we),
      .fill_word    (fill_word),
      .fill_done    (fill_done)
   );

   line_store line_store_i (
      .clk        (clk),
      .ctrl_reset (ctrl_reset),
      .cpu_addr   (cpu_addr),
      .fill_we    (fill_we),
      .fill_word  (fill_word),
      .r_data     (r_data),
      .fill_done  (fill_done),
      .invalidate (invalidate),
      .hit        (hit),
      .cpu_rdata  (cpu_rdata)
   );

   perf_counters #(
      .COUNT_W (COUNT_W)
   ) perf_counters_i (
      .clk        (clk),
      .ctrl_reset (ctrl_reset),
      .hit_event  (hit_event),
      .miss_event (miss_event),
      .stat_req   (stat_req),
      .stat_addr  (stat_addr),
      .stat_data  (stat_data),
      .stat_ack   (stat_ack),
      .invalidate (invalidate)
   );

endmodule

// ==== src/refill_burst.sv ====
`timescale 1ns/1ps

module refill_burst (
   input  logic                               clk,
   input  logic                               ctrl_reset,
   input  logic                               refill_start,
   input  cache_pkg::cache_addr_t             cpu_addr,
   output logic [31:0]                        ar_addr,
   output logic                               ar_valid,
   input  logic                               ar_ready,
   input  logic                               r_valid,
   output logic                               r_ready,
   input  logic                               r_last,
   output logic                               fill_we,
   output logic [cache_pkg::WORD_SEL_W-1:0]   fill_word,
   output logic                               fill_done
);

   localparam logic [1:0] B_IDLE = 2'd0;
   localparam logic [1:0] B_ADDR = 2'd1;
   localparam logic [1:0] B_DATA = 2'd2;

   logic [1:0]             state;
   logic [cache_pkg::WORD_SEL_W-1:0] beat_cnt;
   cache_pkg::cache_addr_t line_addr;

   // request address with word and byte bits cleared
   always_comb
   begin
      line_addr                 = cpu_addr;
      line_addr.fields.word     = '0;
      line_addr.fields.byte_off = '0;
   end

   always_ff @(posedge clk)
   begin
      if (refill_start && state == B_IDLE)
         ar_addr <= {2'b00, line_addr.flat};
   end

   ////////////////////////////////////////
   // address phase and beat counting
   ////////////////////////////////////////
   always_ff @(posedge clk or posedge ctrl_reset)
   begin
      if (ctrl_reset)
      begin
         state     <= B_IDLE;
         ar_valid  <= 1'b0;
         r_ready   <= 1'b0;
         beat_cnt  <= '0;
         fill_done <= 1'b0;
      end
      else
      begin
         fill_done <= 1'b0;
         case (state)
            B_IDLE:
               if (refill_start)
               begin
                  ar_valid <= 1'b1;
                  state    <= B_ADDR;
               end
            B_ADDR:
               if (ar_ready)   // held until accepted
               begin
                  ar_valid <= 1'b0;
                  r_ready  <= 1'b1;
                  beat_cnt <= '0;
                  state    <= B_DATA;
               end
            B_DATA:
               if (r_valid)
               begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (r_last)   // burst end, not the count
                  begin
                     r_ready   <= 1'b0;
                     fill_done <= 1'b1;
                     state     <= B_IDLE;
                  end
               end
            default:
               state <= B_IDLE;
         endcase
      end
   end

   assign fill_we   = (state == B_DATA) && r_valid && r_ready;
   assign fill_word = beat_cnt;   // next free slot in the line

endmodule
